// ==== flist.f ====
design/sched_cfg_pkg.sv
design/sched_types_pkg.sv
design/desc_queue_bank.sv
design/prio_arbiter.sv
design/word_emitter.sv
design/egress_shaper.sv
design/pkt_scheduler_top.sv
bench/sched_checker.sv
bench/sched_tb.sv

// ==== Makefile ====
# Verilator flow for the packet egress scheduler

VERILATOR  ?= verilator
TOP        ?= sched_tb
LINT_TOP   ?= pkt_scheduler_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/sched_tb.sv ====
// Scheduler testbench with clock, reset, random and directed stimulus
// Queue and shaper models, reference word function, compare process, watchdog

`timescale 1ns/100ps

module sched_tb;

    localparam int NUM_PKTS   = 300 + 8 + 16 + 9;
    localparam int TIMEOUT_NS = NUM_PKTS * 24 * 8 * 20 + 20000;
    localparam int QPP        = sched_cfg_pkg::QUEUES_PER_PORT;
    localparam int NP         = sched_cfg_pkg::NUM_PORTS;
    localparam int NQ         = sched_cfg_pkg::NUM_QUEUES;

    logic                       core_clk_ifc;
    logic                       arst_n;
    logic                       enq_valid;
    sched_types_pkg::enq_req_t  enq_req;
    logic                       enq_drop;
    logic                       egr_valid;
    sched_types_pkg::egr_word_t egr_word;

    // Queue model, lengths and enqueue cycles in arrival order
    int          mlen [NQ][$];
    int          mcyc [NQ][$];
    int          mword [NQ];
    // Port lock, round-robin pointer and credits, last four cycles kept
    bit          in_pkt [NP];
    int          lock_q [NP];
    int          rr_ptr;
    int          credit_cur [NP];
    int          credit_hist [4][NP];
    bit          drop_at [int];
    logic [31:0] lcg_state = 32'hd6ad;
    int          cyc;
    int          errors;
    int          checks;
    int          drop_pulses;
    string       test_name;

    pkt_scheduler_top pkt_scheduler_top_i (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .enq_valid    ( enq_valid    ),
        .enq_req      ( enq_req      ),
        .enq_drop     ( enq_drop     ),
        .egr_valid    ( egr_valid    ),
        .egr_word     ( egr_word     )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) cyc <= cyc + 1;

    function automatic int rand_below(int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:8]) % n;
    endfunction

    // Word k of a packet of len bytes on queue q
    function automatic sched_types_pkg::egr_word_t ref_word(int q, int k, int len);
        sched_types_pkg::egr_word_t w;
        int rem;
        int nbytes;
        rem    = len - k * sched_cfg_pkg::WORD_BYTES;
        nbytes = (rem > sched_cfg_pkg::WORD_BYTES) ? sched_cfg_pkg::WORD_BYTES : rem;
        w       = '0;
        w.port  = sched_cfg_pkg::PORT_W'(q / QPP);
        w.queue = sched_cfg_pkg::QUEUE_W'(q);
        for (int i = 0; i < nbytes; i++) begin
            w.keep[i] = 1'b1;
        end
        w.bytes = sched_cfg_pkg::WBYTES_W'(nbytes);
        w.last  = (rem <= sched_cfg_pkg::WORD_BYTES);
        return w;
    endfunction

    // Head descriptor was visible to the arbiter two cycles back
    function automatic bit queue_waiting(int q);
        return mcyc[q].size() > 0 && mcyc[q][0] <= cyc - 3;
    endfunction

    function automatic bit port_waiting(int p);
        bit any;
        any = 1'b0;
        for (int i = 0; i < QPP; i++) begin
            any = any | queue_waiting(p * QPP + i);
        end
        return any;
    endfunction

    task automatic mismatch(string what, logic [127:0] exp_v, logic [127:0] act_v);
        errors++;
        $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    endtask

    task automatic failure(string msg);
        errors++;
        $display("Error in %s at cycle %0d: %s", test_name, cyc, msg);
    endtask

    //////////////////////////////////////////////////
    // Compare process, mid-cycle sampling

    task automatic check_cycle();
        sched_types_pkg::egr_word_t exp_w;
        logic [NP-1:0]              elig;
        int                         exp_port;
        int                         pp;
        int                         q;
        int                         pw;
        int                         charge;
        bit                         exp_drop;
        for (int p = 0; p < NP; p++) begin
            credit_hist[cyc % 4][p] = credit_cur[p];
            elig[p] = credit_hist[(cyc + 2) % 4][p] < 0 && (in_pkt[p] || port_waiting(p));
        end
        // Replay of the round-robin choice made two cycles back
        exp_port = -1;
        for (int i = 0; i < NP; i++) begin
            pp = (rr_ptr + i) % NP;
            if (exp_port < 0 && elig[pp]) begin
                exp_port = pp;
            end
        end
        exp_drop = drop_at.exists(cyc - 1) ? drop_at[cyc - 1] : 1'b0;
        if (enq_drop === 1'b1) begin
            drop_pulses++;
        end
        assert (enq_drop === exp_drop) else mismatch("enq_drop", 128'(exp_drop), 128'(enq_drop));
        assert (egr_valid === (exp_port >= 0))
            else mismatch("egr_valid", 128'(exp_port >= 0), 128'(egr_valid));
        pw     = -1;
        charge = 0;
        if (egr_valid === 1'b1) begin
            q  = int'(egr_word.queue);
            pw = q / QPP;
            checks++;
            assert (pw == exp_port) else mismatch("granted port", 128'(exp_port), 128'(pw));
            assert (credit_hist[(cyc + 2) % 4][pw] < 0)
                else failure("word sent while its port had no credit");
            if (mlen[q].size() == 0) begin
                failure("word on a queue with no packet waiting");
            end else begin
                if (in_pkt[pw]) begin
                    assert (q == lock_q[pw])
                        else mismatch("packet continuity", 128'(lock_q[pw]), 128'(q));
                end else begin
                    for (int pr = q % QPP + 1; pr < QPP; pr++) begin
                        assert (!queue_waiting(pw * QPP + pr))
                            else failure("packet started while a higher priority queue waited");
                    end
                end
                exp_w = ref_word(q, mword[q], mlen[q][0]);
                assert (egr_word === exp_w) else mismatch("word", 128'(exp_w), 128'(egr_word));
                charge = int'(exp_w.bytes) + (exp_w.last ? sched_cfg_pkg::ETH_OVERHEAD : 0);
                in_pkt[pw] = !exp_w.last;
                lock_q[pw] = q;
                mword[q]++;
                if (exp_w.last) begin
                    void'(mlen[q].pop_front());
                    void'(mcyc[q].pop_front());
                    mword[q] = 0;
                end
            end
            rr_ptr = (pw + 1) % NP;
        end
        for (int p = 0; p < NP; p++) begin
            if (p == pw) begin
                credit_cur[p] += charge - sched_cfg_pkg::SHAPER_DRAIN;
            end else if (credit_cur[p] >= 0) begin
                credit_cur[p] -= sched_cfg_pkg::SHAPER_DRAIN;
            end
        end
    endtask

    always @(negedge core_clk_ifc) begin
        if (arst_n) begin
            check_cycle();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic next_cycle();
        @(posedge core_clk_ifc);
        #2;
        enq_valid = 1'b0;
    endtask

    task automatic enqueue(int q, int len);
        bit full;
        full           = mlen[q].size() >= sched_cfg_pkg::QUEUE_DEPTH;
        enq_valid      = 1'b1;
        enq_req.queue  = sched_cfg_pkg::QUEUE_W'(q);
        enq_req.length = sched_cfg_pkg::LEN_W'(len);
        drop_at[cyc]   = full;
        if (!full) begin
            mlen[q].push_back(len);
            mcyc[q].push_back(cyc);
        end
    endtask

    task automatic wait_drained();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge core_clk_ifc);
            busy = 1'b0;
            for (int q = 0; q < NQ; q++) begin
                busy = busy | (mlen[q].size() != 0);
            end
        end
        repeat (8) @(posedge core_clk_ifc);
    endtask

    initial begin
        int q;
        int sent;
        arst_n    = 1'b0;
        enq_valid = 1'b0;
        enq_req   = '0;
        rr_ptr    = 0;
        test_name = "reset";
        for (int p = 0; p < NP; p++) begin
            in_pkt[p]     = 1'b0;
            credit_cur[p] = -1;
            for (int h = 0; h < 4; h++) begin
                credit_hist[h][p] = -1;
            end
        end
        repeat (10) @(posedge core_clk_ifc);
        #2;
        arst_n = 1'b1;

        test_name = "smoke";
        sent      = 0;
        while (sent < 300) begin
            next_cycle();
            q = rand_below(NQ);
            // Headroom of one entry keeps random traffic clear of drops
            if (mlen[q].size() < sched_cfg_pkg::QUEUE_DEPTH - 1) begin
                enqueue(q, rand_below(sched_cfg_pkg::MTU_BYTES) + 1);
                sent++;
            end
        end
        next_cycle();
        wait_drained();

        test_name = "shaping_one_port";
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            enqueue(QPP + rand_below(QPP), 1000);
        end
        next_cycle();
        wait_drained();

        test_name = "shaping_all_ports";
        for (int i = 0; i < NQ; i++) begin
            next_cycle();
            enqueue(i, 1000);
        end
        next_cycle();
        wait_drained();

        // Ninth back-to-back packet meets a full queue
        test_name   = "drop";
        drop_pulses = 0;
        for (int i = 0; i < 9; i++) begin
            next_cycle();
            enqueue(9, 1000);
        end
        next_cycle();
        wait_drained();
        assert (drop_pulses == 1) else mismatch("drop pulses", 128'(1), 128'(drop_pulses));

        errors += pkt_scheduler_top_i.sched_checker_i.fail_count;
        $display("Checks %0d, errors %0d, drops %0d", checks, errors, drop_pulses);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: scheduler still busy after %0d ns in %s", TIMEOUT_NS, test_name);
        $display("Checks %0d, errors %0d, drops %0d", checks, errors + 1, drop_pulses);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== bench/sched_checker.sv ====
// Concurrent assertions on the scheduler outputs
// Bound into the scheduler top level

`timescale 1ns/100ps

module sched_checker (
    input logic                       core_clk_ifc,
    input logic                       arst_n,
    input logic                       enq_valid,
    input logic                       enq_drop,
    input logic                       egr_valid,
    input sched_types_pkg::egr_word_t egr_word
);

    int   fail_count = 0;
    logic seen_enq;

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            seen_enq <= 1'b0;
        end else if (enq_valid) begin
            seen_enq <= 1'b1;
        end
    end

    // Outputs stay quiet until the first descriptor
    quiet_until_enq: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        !seen_enq |-> !egr_valid && !enq_drop)
        else begin
            fail_count++;
            $error("egr_valid or enq_drop raised before any enqueue");
        end

    // Low bytes only, never empty
    keep_thermometer: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        egr_valid |-> egr_word.keep != '0 &&
        (egr_word.keep & (egr_word.keep + sched_cfg_pkg::WORD_BYTES'(1))) == '0)
        else begin
            fail_count++;
            $error("keep mask is empty or not a thermometer");
        end

    keep_count: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        egr_valid |-> $countones(egr_word.keep) == int'(egr_word.bytes))
        else begin
            fail_count++;
            $error("keep mask population differs from the byte count");
        end

    full_middle_words: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        egr_valid && !egr_word.last |-> int'(egr_word.bytes) == sched_cfg_pkg::WORD_BYTES)
        else begin
            fail_count++;
            $error("word before the last one is not a full word");
        end

endmodule

bind pkt_scheduler_top sched_checker sched_checker_i (
    .core_clk_ifc ( core_clk_ifc ),
    .arst_n       ( arst_n       ),
    .enq_valid    ( enq_valid    ),
    .enq_drop     ( enq_drop     ),
    .egr_valid    ( egr_valid    ),
    .egr_word     ( egr_word     )
);

// ==== design/pkt_scheduler_top.sv ====
// Packet egress scheduler top level
// Queue bank, arbiter, word emitter and shaper

`timescale 1ns/100ps

module pkt_scheduler_top (
    input  logic                       core_clk_ifc,
    input  logic                       arst_n,
    input  logic                       enq_valid,
    input  sched_types_pkg::enq_req_t  enq_req,
    output logic                       enq_drop,
    output logic                       egr_valid,
    output sched_types_pkg::egr_word_t egr_word
);

    logic [sched_cfg_pkg::NUM_QUEUES-1:0] nonempty;
    logic [sched_cfg_pkg::NUM_QUEUES-1:0] head_last;
    logic [sched_cfg_pkg::WBYTES_W-1:0]   head_bytes;
    logic [sched_cfg_pkg::NUM_PORTS-1:0]  port_ready;
    logic                                 grant_valid;
    sched_types_pkg::grant_t              grant;

    desc_queue_bank desc_queue_bank_i (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .enq_valid    ( enq_valid    ),
        .enq_req      ( enq_req      ),
        .grant_valid  ( grant_valid  ),
        .grant        ( grant        ),
        .enq_drop     ( enq_drop     ),
        .nonempty     ( nonempty     ),
        .head_last    ( head_last    ),
        .head_bytes   ( head_bytes   )
    );

    prio_arbiter prio_arbiter_i (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .nonempty     ( nonempty     ),
        .head_last    ( head_last    ),
        .head_bytes   ( head_bytes   ),
        .port_ready   ( port_ready   ),
        .grant_valid  ( grant_valid  ),
        .grant        ( grant        )
    );

    word_emitter word_emitter_i (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .grant_valid  ( grant_valid  ),
        .grant        ( grant        ),
        .egr_valid    ( egr_valid    ),
        .egr_word     ( egr_word     )
    );

    egress_shaper egress_shaper_i (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .egr_valid    ( egr_valid    ),
        .egr_word     ( egr_word     ),
        .port_ready   ( port_ready   )
    );

endmodule

// ==== design/egress_shaper.sv ====
// Per-port integer credit shapers
// Ready vector from the credit sign bits

`timescale 1ns/100ps

module egress_shaper (
    input  logic                                core_clk_ifc,
    input  logic                                arst_n,
    input  logic                                egr_valid,
    input  sched_types_pkg::egr_word_t          egr_word,
    output logic [sched_cfg_pkg::NUM_PORTS-1:0] port_ready
);

    logic signed [sched_cfg_pkg::CREDIT_W-1:0] credit [sched_cfg_pkg::NUM_PORTS];
    logic signed [sched_cfg_pkg::CREDIT_W-1:0] charge;

    // Word bytes plus the per-packet overhead on the last word
    assign charge = sched_cfg_pkg::CREDIT_W'(egr_word.bytes) +
                    (egr_word.last ? sched_cfg_pkg::CREDIT_W'(sched_cfg_pkg::ETH_OVERHEAD)
                                   : '0);

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < sched_cfg_pkg::NUM_PORTS; p++) begin
                credit[p] <= '1;
            end
        end else begin
            for (int p = 0; p < sched_cfg_pkg::NUM_PORTS; p++) begin
                if (egr_valid && egr_word.port == sched_cfg_pkg::PORT_W'(p)) begin
                    credit[p] <= credit[p] + charge -
                                 sched_cfg_pkg::CREDIT_W'(sched_cfg_pkg::SHAPER_DRAIN);
                end else if (!credit[p][sched_cfg_pkg::CREDIT_W-1]) begin
                    // Idle drain stops once the credit goes negative
                    credit[p] <= credit[p] -
                                 sched_cfg_pkg::CREDIT_W'(sched_cfg_pkg::SHAPER_DRAIN);
                end
            end
        end
    end

    // Ready while the credit is negative
    always_comb begin
        for (int p = 0; p < sched_cfg_pkg::NUM_PORTS; p++) begin
            port_ready[p] = credit[p][sched_cfg_pkg::CREDIT_W-1];
        end
    end

endmodule

// ==== design/word_emitter.sv ====
// Two-stage egress pipeline
// Grant register, then port, keep mask and last flag

`timescale 1ns/100ps

module word_emitter (
    input  logic                       core_clk_ifc,
    input  logic                       arst_n,
    input  logic                       grant_valid,
    input  sched_types_pkg::grant_t    grant,
    output logic                       egr_valid,
    output sched_types_pkg::egr_word_t egr_word
);

    logic                                 s1_valid;
    sched_types_pkg::grant_t              s1_grant;
    logic [sched_cfg_pkg::WORD_BYTES-1:0] keep_next;

    // Thermometer mask, low bytes valid
    always_comb begin
        for (int i = 0; i < sched_cfg_pkg::WORD_BYTES; i++) begin
            keep_next[i] = (sched_cfg_pkg::WBYTES_W'(i) < s1_grant.bytes);
        end
    end

    //////////////////////////////////////////////////
    // Valid pipe

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            egr_valid <= 1'b0;
        end else begin
            s1_valid  <= grant_valid;
            egr_valid <= s1_valid;
        end
    end

    //////////////////////////////////////////////////
    // Payload pipe

    always_ff @(posedge core_clk_ifc) begin
        if (grant_valid) begin
            s1_grant <= grant;
        end
        if (s1_valid) begin
            // Port sits in the upper bits of the queue number
            egr_word.port  <= s1_grant.queue[sched_cfg_pkg::QUEUE_W-1 -: sched_cfg_pkg::PORT_W];
            egr_word.queue <= s1_grant.queue;
            egr_word.keep  <= keep_next;
            egr_word.bytes <= s1_grant.bytes;
            egr_word.last  <= s1_grant.last;
        end
    end

endmodule

// ==== design/prio_arbiter.sv ====
// Port lock state, strict priority at packet start
// Port round-robin and word grant

`timescale 1ns/100ps

module prio_arbiter (
    input  logic                                 core_clk_ifc,
    input  logic                                 arst_n,
    input  logic [sched_cfg_pkg::NUM_QUEUES-1:0] nonempty,
    input  logic [sched_cfg_pkg::NUM_QUEUES-1:0] head_last,
    input  logic [sched_cfg_pkg::WBYTES_W-1:0]   head_bytes,
    input  logic [sched_cfg_pkg::NUM_PORTS-1:0]  port_ready,
    output logic                                 grant_valid,
    output sched_types_pkg::grant_t              grant
);

    sched_types_pkg::port_state_e       state     [sched_cfg_pkg::NUM_PORTS];
    logic [sched_cfg_pkg::PRIO_W-1:0]   lock_prio [sched_cfg_pkg::NUM_PORTS];
    logic [sched_cfg_pkg::PRIO_W-1:0]   cand_prio [sched_cfg_pkg::NUM_PORTS];
    logic [sched_cfg_pkg::NUM_PORTS-1:0] eligible;
    logic [sched_cfg_pkg::PORT_W-1:0]   rr_ptr;
    logic [sched_cfg_pkg::PORT_W-1:0]   sel_port;
    logic [sched_cfg_pkg::QUEUE_W-1:0]  sel_queue;

    //////////////////////////////////////////////////
    // Per-port candidate queue

    always_comb begin
        for (int p = 0; p < sched_cfg_pkg::NUM_PORTS; p++) begin
            cand_prio[p] = '0;
            eligible[p]  = 1'b0;
            if (state[p] == sched_types_pkg::PORT_IN_PACKET) begin
                // Locked queue keeps the port
                cand_prio[p] = lock_prio[p];
                eligible[p]  = port_ready[p];
            end else begin
                // Ascending scan, so the highest nonempty priority wins
                for (int i = 0; i < sched_cfg_pkg::QUEUES_PER_PORT; i++) begin
                    if (nonempty[p * sched_cfg_pkg::QUEUES_PER_PORT + i]) begin
                        cand_prio[p] = sched_cfg_pkg::PRIO_W'(i);
                        eligible[p]  = port_ready[p];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Round-robin over eligible ports

    // Pointer wraps in PORT_W bits, NUM_PORTS is a power of two
    always_comb begin
        logic [sched_cfg_pkg::PORT_W-1:0] idx;
        idx         = rr_ptr;
        grant_valid = 1'b0;
        sel_port    = rr_ptr;
        for (int i = 0; i < sched_cfg_pkg::NUM_PORTS; i++) begin
            idx = rr_ptr + sched_cfg_pkg::PORT_W'(i);
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                sel_port    = idx;
            end
        end
    end

    assign sel_queue   = {sel_port, cand_prio[sel_port]};
    assign grant.queue = sel_queue;
    assign grant.bytes = head_bytes;
    assign grant.last  = head_last[sel_queue];

    //////////////////////////////////////////////////
    // Lock state and pointer

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr <= '0;
            for (int p = 0; p < sched_cfg_pkg::NUM_PORTS; p++) begin
                state[p] <= sched_types_pkg::PORT_IDLE;
            end
        end else if (grant_valid) begin
            rr_ptr <= sel_port + 1'b1;
            // Last word frees the port, any other word holds it
            if (grant.last) begin
                state[sel_port] <= sched_types_pkg::PORT_IDLE;
            end else begin
                state[sel_port] <= sched_types_pkg::PORT_IN_PACKET;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (grant_valid && state[sel_port] == sched_types_pkg::PORT_IDLE) begin
            lock_prio[sel_port] <= cand_prio[sel_port];
        end
    end

endmodule

// ==== design/desc_queue_bank.sv ====
// Per-queue descriptor FIFOs with head remainder tracking
// Enqueue with drop on full, word consumption and head pop

`timescale 1ns/100ps

module desc_queue_bank (
    input  logic                                 core_clk_ifc,
    input  logic                                 arst_n,
    input  logic                                 enq_valid,
    input  sched_types_pkg::enq_req_t            enq_req,
    input  logic                                 grant_valid,
    input  sched_types_pkg::grant_t              grant,
    output logic                                 enq_drop,
    output logic [sched_cfg_pkg::NUM_QUEUES-1:0] nonempty,
    output logic [sched_cfg_pkg::NUM_QUEUES-1:0] head_last,
    output logic [sched_cfg_pkg::WBYTES_W-1:0]   head_bytes
);

    logic [sched_cfg_pkg::NUM_QUEUES-1:0] full;
    logic [sched_cfg_pkg::WBYTES_W-1:0]   word_size [sched_cfg_pkg::NUM_QUEUES];

    for (genvar q = 0; q < sched_cfg_pkg::NUM_QUEUES; q++) begin : g_queue

        logic [sched_cfg_pkg::LEN_W-1:0]  len_mem [sched_cfg_pkg::QUEUE_DEPTH];
        logic [sched_cfg_pkg::QPTR_W-1:0] rd_ptr;
        logic [sched_cfg_pkg::QPTR_W-1:0] wr_ptr;
        logic [sched_cfg_pkg::QPTR_W-1:0] rd_next;
        logic [sched_cfg_pkg::QCNT_W-1:0] count;
        logic [sched_cfg_pkg::LEN_W-1:0]  head_rem;
        logic                             push;
        logic                             hit_grant;
        logic                             pop;

        assign full[q]   = (count == sched_cfg_pkg::QCNT_W'(sched_cfg_pkg::QUEUE_DEPTH));
        assign push      = enq_valid && !full[q] &&
                           (enq_req.queue == sched_cfg_pkg::QUEUE_W'(q));
        assign hit_grant = grant_valid && (grant.queue == sched_cfg_pkg::QUEUE_W'(q));
        assign pop       = hit_grant && grant.last;
        assign rd_next   = rd_ptr + 1'b1;

        assign nonempty[q]  = (count != '0);
        assign head_last[q] = (head_rem <= sched_cfg_pkg::LEN_W'(sched_cfg_pkg::WORD_BYTES));
        // min(remainder, WORD_BYTES)
        assign word_size[q] = head_last[q] ? sched_cfg_pkg::WBYTES_W'(head_rem)
                                           : sched_cfg_pkg::WBYTES_W'(sched_cfg_pkg::WORD_BYTES);

        always_ff @(posedge core_clk_ifc) begin
            if (push) begin
                len_mem[wr_ptr] <= enq_req.length;
            end
        end

        always_ff @(posedge core_clk_ifc or negedge arst_n) begin
            if (!arst_n) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_next;
                end
                if (push && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !push) begin
                    count <= count - 1'b1;
                end
            end
        end

        // Head remainder, reloaded whenever a new descriptor reaches the head
        always_ff @(posedge core_clk_ifc) begin
            if (pop) begin
                if (count != sched_cfg_pkg::QCNT_W'(1)) begin
                    head_rem <= len_mem[rd_next];
                end else if (push) begin
                    // Queue drains and refills in the same cycle
                    head_rem <= enq_req.length;
                end
            end else if (hit_grant) begin
                head_rem <= head_rem - sched_cfg_pkg::LEN_W'(sched_cfg_pkg::WORD_BYTES);
            end else if (push && count == '0) begin
                head_rem <= enq_req.length;
            end
        end

    end

    assign head_bytes = word_size[grant.queue];

    //////////////////////////////////////////////////
    // Drop flag, one cycle after the rejected strobe

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            enq_drop <= 1'b0;
        end else begin
            enq_drop <= enq_valid && full[enq_req.queue];
        end
    end

endmodule

// ==== design/sched_types_pkg.sv ====
// Scheduler packed structs for enqueue, grant and egress words
// Port lock state enum

package sched_types_pkg;

    //////////////////////////////////////////////////
    // Descriptor in

    typedef struct packed {
        logic [sched_cfg_pkg::QUEUE_W-1:0] queue;
        logic [sched_cfg_pkg::LEN_W-1:0]   length;
    } enq_req_t;

    //////////////////////////////////////////////////
    // Arbiter grant, one word of one packet

    typedef struct packed {
        logic [sched_cfg_pkg::QUEUE_W-1:0]  queue;
        // 1 to WORD_BYTES
        logic [sched_cfg_pkg::WBYTES_W-1:0] bytes;
        logic                               last;
    } grant_t;

    //////////////////////////////////////////////////
    // Egress word

    typedef struct packed {
        logic [sched_cfg_pkg::PORT_W-1:0]     port;
        logic [sched_cfg_pkg::QUEUE_W-1:0]    queue;
        logic [sched_cfg_pkg::WORD_BYTES-1:0] keep;
        logic [sched_cfg_pkg::WBYTES_W-1:0]   bytes;
        logic                                 last;
    } egr_word_t;

    // Port owned by a packet until its last word
    typedef enum logic {
        PORT_IDLE      = 1'b0,
        PORT_IN_PACKET = 1'b1
    } port_state_e;

endpackage

// ==== design/sched_cfg_pkg.sv ====
// Scheduler sizing constants
// Port, queue, word and shaper widths derived from them

package sched_cfg_pkg;

    //////////////////////////////////////////////////
    // Ports and queues

    localparam int NUM_PORTS       = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT;

    // Queue number is {port, prio}
    localparam int PORT_W  = $clog2(NUM_PORTS);
    localparam int PRIO_W  = $clog2(QUEUES_PER_PORT);
    localparam int QUEUE_W = PORT_W + PRIO_W;

    // Descriptor FIFO per queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = QPTR_W + 1;

    //////////////////////////////////////////////////
    // Words, packets and shaping

    localparam int WORD_BYTES = 64;
    localparam int WBYTES_W   = $clog2(WORD_BYTES) + 1;
    localparam int MTU_BYTES  = 1500;
    localparam int LEN_W      = $clog2(MTU_BYTES + 1);

    // 64-bit line at core rate
    localparam int SHAPER_DRAIN = 8;
    localparam int ETH_OVERHEAD = 20;
    localparam int CREDIT_W     = 13;

endpackage
